/* project.f */
+incdir+include
logic/microCpuPkg.sv
logic/alu.sv
logic/registerDatapath.sv
logic/instrSequencer.sv
logic/microCpu.sv
sim/microCpu_sva.sv
sim/microCpuTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module microCpuTb -o microCpuSim

./obj_dir/microCpuSim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* sim/microCpuTb.sv */
`timescale 1ns/100ps
`include "microCpu_params.svh"

module microCpuTb;
    import microCpuPkg::*;

    localparam int RUNS         = 12;
    // Instructions per program, not counting the closing end thread
    localparam int PROG_LEN     = 14;
    localparam int DRAIN_CYCLES = 30;
    // Main program plus one thread, at most five cycles per instruction
    localparam int RUN_CYCLES   = 2 * (PROG_LEN + 1) * 5 + 8 + DRAIN_CYCLES + 20;
    localparam int WATCHDOG_NS  = RUNS * RUN_CYCLES * 4 + 1000;

    logic                   CLK = 1'b0;
    logic                   RESET;
    logic [`DATA_WIDTH-1:0] romAddress;
    logic [`DATA_WIDTH-1:0] romData;
    logic [`DATA_WIDTH-1:0] busDataIn;
    busReq_t                busReq;
    logic [`IRQ_COUNT-1:0]  irqRaise;
    logic [`IRQ_COUNT-1:0]  irqAck;

    // Memory images, the reference model keeps its own RAM copy
    logic [7:0]            rom [256];
    logic [7:0]            tbRam [256];
    logic [7:0]            modelRam [256];
    logic [7:0]            modelA;
    logic [7:0]            modelB;
    // Expected bus writes as {addr, data}
    logic [15:0]           expectedWrites [$];
    logic [7:0]            romSeen = 8'h00;
    logic [7:0]            busAddrSeen = `IDLE_BUS_ADDR;
    logic [`IRQ_COUNT-1:0] expectedAck;
    logic                  ackPending = 1'b0;
    int                    writesSeen;
    int                    mainWriteCount;

    microCpu uut (
        .CLK        (CLK),
        .RESET      (RESET),
        .romAddress (romAddress),
        .romData    (romData),
        .busDataIn  (busDataIn),
        .busReq     (busReq),
        .irqRaise   (irqRaise),
        .irqAck     (irqAck)
    );

    always #2 CLK = ~CLK;

    //////////////////////////////////////////////////
    // ROM and RAM models
    //////////////////////////////////////////////////

    // One cycle of latency, address taken mid-cycle
    always @(posedge CLK) begin
        #1;
        romData   = rom[romSeen];
        busDataIn = tbRam[busAddrSeen];
    end

    // Bus monitor, write pulses and acks checked against the model
    always @(negedge CLK) begin
        romSeen     = romAddress;
        busAddrSeen = busReq.addr;
        if (!RESET && busReq.writeEnable) begin
            if (expectedWrites.size() == 0) begin
                reportFailure("write pulse seen while no write was expected");
            end else begin
                checkValue("busReq.addr", busReq.addr, expectedWrites[0][15:8]);
                checkValue("busReq.data", busReq.data, expectedWrites[0][7:0]);
                void'(expectedWrites.pop_front());
                tbRam[busReq.addr] = busReq.data;
                writesSeen++;
            end
        end
        if (!RESET && irqAck != '0) begin
            if (!ackPending) begin
                reportFailure("irqAck pulse seen while no interrupt was pending");
            end else begin
                checkValue("irqAck", irqAck, expectedAck);
                // Thread must start only after the main program wrote everything
                checkValue("writeCount at irqAck", writesSeen, mainWriteCount);
                ackPending = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic stopOnFailure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportFailure(input string message);
        $display("ERROR: %s", message);
        stopOnFailure();
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            stopOnFailure();
        end
    endtask

    task automatic waitCycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic waitForAck();
        int cycles;
        cycles = 0;
        while (ackPending && cycles < RUN_CYCLES) begin
            waitCycle();
            cycles++;
        end
        if (ackPending) begin
            reportFailure("no irqAck pulse after the main program ended");
        end
    endtask

    task automatic waitForWrites();
        int cycles;
        cycles = 0;
        while (expectedWrites.size() != 0 && cycles < RUN_CYCLES) begin
            waitCycle();
            cycles++;
        end
        if (expectedWrites.size() != 0) begin
            reportFailure("expected bus writes never appeared");
        end
    endtask

    //////////////////////////////////////////////////
    // Program generator
    //////////////////////////////////////////////////

    // Kept codes only, writes drawn twice as often
    function automatic logic [3:0] randomCode();
        int pick;
        pick = $urandom_range(0, 11);
        if (pick >= 10) begin
            return 4'(pick - 8);
        end else if (pick >= 8) begin
            return 4'(pick + 5);
        end
        return 4'(pick);
    endfunction

    task automatic writeProgram(input logic [7:0] base);
        logic [7:0] starts [PROG_LEN+1];
        logic [3:0] codes [PROG_LEN+1];
        logic [7:0] addr;
        logic [3:0] high;
        addr = base;
        // First pass lays out instruction start addresses
        for (int i = 0; i <= PROG_LEN; i++) begin
            codes[i]  = (i == PROG_LEN) ? 4'h8 : randomCode();
            starts[i] = addr;
            addr      = addr + ((codes[i] inside {4'h4, 4'h5, 4'h8}) ? 8'd1 : 8'd2);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            case (codes[i])
                // Op 6 is undefined and must give zero
                4'h4, 4'h5: high = 4'($urandom_range(0, 6));
                // Cond 3 never branches
                4'h6:       high = 4'($urandom_range(0, 3));
                default:    high = 4'($urandom);
            endcase
            rom[starts[i]] = {high, codes[i]};
            // Targets only ever point at a later instruction
            if (codes[i] inside {4'h6, 4'h7}) begin
                rom[starts[i] + 8'd1] = starts[$urandom_range(i + 1, PROG_LEN)];
            end else if (codes[i] inside {4'hD, 4'hE}) begin
                // Small immediates so equal compares happen
                rom[starts[i] + 8'd1] = 8'($urandom_range(0, 7));
            end else if (!(codes[i] inside {4'h4, 4'h5})) begin
                rom[starts[i] + 8'd1] = 8'($urandom);
            end
        end
        rom[starts[PROG_LEN]] = 8'h08;
    endtask

    task automatic buildMemories();
        for (int a = 0; a < 256; a++) begin
            // Unused ROM decodes as end thread
            rom[a]      = {a[7:4] ^ a[3:0], 4'h8};
            tbRam[a]    = 8'($urandom);
            modelRam[a] = tbRam[a];
        end
        writeProgram(8'h00);
        writeProgram(8'h50);
        writeProgram(8'hA0);
        rom[`IRQ_A_VECTOR] = 8'h50;
        rom[`IRQ_B_VECTOR] = 8'hA0;
    endtask

    //////////////////////////////////////////////////
    // ISA reference model
    //////////////////////////////////////////////////

    function automatic logic [7:0] expectedMaths(input logic [3:0] op, input logic [7:0] a,
                                                 input logic [7:0] b);
        case (op)
            4'h0:    return a + b;
            4'h1:    return a - b;
            4'h2:    return a & b;
            4'h3:    return a | b;
            4'h4:    return a ^ b;
            4'h5:    return {a[6:0], 1'b0};
            default: return 8'h00;
        endcase
    endfunction

    // Unsigned compare of A against B
    function automatic logic expectedCondition(input logic [3:0] cond, input logic [7:0] a,
                                               input logic [7:0] b);
        case (cond)
            4'h0:    return a == b;
            4'h1:    return a > b;
            4'h2:    return a < b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic setModelRegister(input logic selectB, input logic [7:0] value);
        if (selectB) begin
            modelB = value;
        end else begin
            modelA = value;
        end
    endtask

    task automatic runModelThread(input logic [7:0] startPc);
        logic [7:0] pc;
        logic [7:0] instr;
        logic [7:0] operand;
        int         steps;
        pc    = startPc;
        steps = 0;
        instr = rom[pc];
        while (instr[3:0] != 4'h8 && steps <= PROG_LEN) begin
            operand = rom[pc + 8'd1];
            case (instr[3:0])
                4'h0, 4'h1: begin
                    setModelRegister(instr[0], modelRam[operand]);
                    pc = pc + 8'd2;
                end
                4'h2, 4'h3: begin
                    expectedWrites.push_back({operand, instr[0] ? modelB : modelA});
                    modelRam[operand] = instr[0] ? modelB : modelA;
                    pc = pc + 8'd2;
                end
                4'h4, 4'h5: begin
                    setModelRegister(instr[0], expectedMaths(instr[7:4], modelA, modelB));
                    pc = pc + 8'd1;
                end
                4'h6: pc = expectedCondition(instr[7:4], modelA, modelB) ? operand : pc + 8'd2;
                4'h7: pc = operand;
                4'hD, 4'hE: begin
                    setModelRegister(instr[3:0] == 4'hE, operand);
                    pc = pc + 8'd2;
                end
                default: steps = PROG_LEN;
            endcase
            steps++;
            instr = rom[pc];
        end
        if (instr[3:0] != 4'h8) begin
            reportFailure("reference model did not reach end thread");
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    task automatic runOneProgram(input int run);
        logic [1:0] pattern;
        // Cycle through line 0, line 1 and both lines
        pattern = 2'(run % 3 + 1);
        RESET   = 1'b1;
        buildMemories();
        modelA = '0;
        modelB = '0;
        runModelThread(8'h00);
        mainWriteCount = expectedWrites.size();
        // Line 0 wins when both are raised
        expectedAck = pattern[0] ? 2'b01 : 2'b10;
        runModelThread(pattern[0] ? rom[`IRQ_A_VECTOR] : rom[`IRQ_B_VECTOR]);
        writesSeen = 0;
        ackPending = 1'b1;
        repeat (8) waitCycle();
        RESET    = 1'b0;
        // Level is only looked at once the main program is idle
        irqRaise = pattern;
        repeat (2) begin
            @(negedge CLK);
            checkValue("busReq.addr", busReq.addr, `IDLE_BUS_ADDR);
            checkValue("busReq.writeEnable", busReq.writeEnable, 1'b0);
            checkValue("irqAck", irqAck, 2'b00);
        end
        waitForAck();
        irqRaise = '0;
        waitForWrites();
        // Catches stray writes after the thread
        repeat (DRAIN_CYCLES) waitCycle();
    endtask

    initial begin
        void'($urandom(29701));
        RESET     = 1'b1;
        irqRaise  = '0;
        romData   = '0;
        busDataIn = '0;
        for (int run = 0; run < RUNS; run++) begin
            runOneProgram(run);
        end
        if (expectedWrites.size() == 0 && !ackPending) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            reportFailure("writes or acknowledges still outstanding at the end");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        reportFailure("watchdog expired before all programs finished");
    end

endmodule

/* sim/microCpu_sva.sv */
`timescale 1ns/100ps
`include "microCpu_params.svh"

module microCpuSva (
    input logic                  CLK,
    input logic                  RESET,
    input microCpuPkg::busReq_t  busReq,
    input logic [`IRQ_COUNT-1:0] irqAck
);

    // Write strobe is a single-cycle pulse
    writeSingle: assert property (@(posedge CLK) disable iff (RESET)
        busReq.writeEnable |=> !busReq.writeEnable)
        else $error("writeEnable high for two cycles in a row");

    // At most one line acknowledged
    ackOneHot: assert property (@(posedge CLK) disable iff (RESET)
        $onehot0(irqAck))
        else $error("irqAck has more than one line set");

    ackSingle: assert property (@(posedge CLK) disable iff (RESET)
        (irqAck != '0) |=> (irqAck == '0))
        else $error("irqAck high for two cycles in a row");

    // Strobes quiet straight out of reset
    resetQuiet: assert property (@(posedge CLK)
        RESET |=> (!busReq.writeEnable && irqAck == '0))
        else $error("writeEnable or irqAck high in the cycle after RESET");

endmodule

bind microCpu microCpuSva protocolChecks (
    .CLK    (CLK),
    .RESET  (RESET),
    .busReq (busReq),
    .irqAck (irqAck)
);

/* logic/microCpu.sv */
`timescale 1ns/100ps
`include "microCpu_params.svh"

module microCpu (
    input  logic                   CLK,
    input  logic                   RESET,
    output logic [`DATA_WIDTH-1:0] romAddress,
    input  logic [`DATA_WIDTH-1:0] romData,
    input  logic [`DATA_WIDTH-1:0] busDataIn,
    output microCpuPkg::busReq_t   busReq,
    input  logic [`IRQ_COUNT-1:0]  irqRaise,
    output logic [`IRQ_COUNT-1:0]  irqAck
);
    import microCpuPkg::*;

    datapathCtrl_t          ctrl;
    logic                   branchTaken;
    logic                   writeEnable;
    logic [`DATA_WIDTH-1:0] busAddr;
    logic [`DATA_WIDTH-1:0] busDataOut;

    // Control flow, bus addressing and interrupts
    instrSequencer sequencer (
        .CLK         (CLK),
        .RESET       (RESET),
        .romData     (romData),
        .romAddress  (romAddress),
        .branchTaken (branchTaken),
        .irqRaise    (irqRaise),
        .irqAck      (irqAck),
        .busAddr     (busAddr),
        .writeEnable (writeEnable),
        .ctrl        (ctrl)
    );

    // Registers, write data and ALU
    registerDatapath datapath (
        .CLK         (CLK),
        .RESET       (RESET),
        .romData     (romData),
        .busDataIn   (busDataIn),
        .ctrl        (ctrl),
        .busDataOut  (busDataOut),
        .branchTaken (branchTaken)
    );

    // All three bus fields come from flops and line up in the same cycle
    assign busReq.addr        = busAddr;
    assign busReq.data        = busDataOut;
    assign busReq.writeEnable = writeEnable;

endmodule

/* logic/instrSequencer.sv */
`timescale 1ns/100ps
`include "microCpu_params.svh"

module instrSequencer (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic [`DATA_WIDTH-1:0]     romData,
    output logic [`DATA_WIDTH-1:0]     romAddress,
    input  logic                       branchTaken,
    input  logic [`IRQ_COUNT-1:0]      irqRaise,
    output logic [`IRQ_COUNT-1:0]      irqAck,
    output logic [`DATA_WIDTH-1:0]     busAddr,
    output logic                       writeEnable,
    output microCpuPkg::datapathCtrl_t ctrl
);
    import microCpuPkg::*;

    // One short pipeline of states per instruction
    typedef enum logic [4:0] {
        stateIdle, stateThread0, stateThread1, stateThread2,
        stateDecode,
        stateReadStart, stateRead0, stateRead1, stateRead2,
        stateWriteStart, stateWrite0,
        stateMaths, stateMaths0,
        stateBranch, stateBranch0, stateBranch1,
        stateGoto, stateGoto0, stateGoto1,
        stateLoadImm, stateLoadImm0, stateLoadImm1
    } state_t;

    state_t                 state;
    state_t                 nextState;
    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] nextPc;
    logic                   pcOffset;
    logic                   nextPcOffset;
    logic [`DATA_WIDTH-1:0] nextBusAddr;
    logic                   nextWriteEnable;
    logic [`IRQ_COUNT-1:0]  nextIrqAck;
    logic                   regSelectB;
    logic                   nextRegSelectB;
    instrCode_t             fetchCode;

    // Offset reaches the operand byte without moving the PC
    assign romAddress = pc + `DATA_WIDTH'(pcOffset);
    assign fetchCode  = instrCode_t'(romData[3:0]);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state       <= stateDecode;
            pc          <= '0;
            pcOffset    <= 1'b0;
            busAddr     <= `IDLE_BUS_ADDR;
            writeEnable <= 1'b0;
            irqAck      <= '0;
            regSelectB  <= 1'b0;
        end else begin
            state       <= nextState;
            pc          <= nextPc;
            pcOffset    <= nextPcOffset;
            busAddr     <= nextBusAddr;
            writeEnable <= nextWriteEnable;
            irqAck      <= nextIrqAck;
            regSelectB  <= nextRegSelectB;
        end
    end

    always_comb begin
        // Defaults hold the PC, park the bus and raise no strobe
        nextState       = state;
        nextPc          = pc;
        nextPcOffset    = 1'b0;
        nextBusAddr     = `IDLE_BUS_ADDR;
        nextWriteEnable = 1'b0;
        nextIrqAck      = '0;
        nextRegSelectB  = regSelectB;
        ctrl            = '0;
        ctrl.regSelect  = regSelectB;

        case (state)
            //////////////////////////////////////////////////
            // Thread entry
            //////////////////////////////////////////////////
            stateIdle: begin
                // Line 0 wins when both are raised
                if (irqRaise[0]) begin
                    nextState     = stateThread0;
                    nextPc        = `IRQ_A_VECTOR;
                    nextIrqAck[0] = 1'b1;
                end else if (irqRaise[1]) begin
                    nextState     = stateThread0;
                    nextPc        = `IRQ_B_VECTOR;
                    nextIrqAck[1] = 1'b1;
                end
            end
            // Vector address on the ROM this cycle
            stateThread0: nextState = stateThread1;
            stateThread1: begin
                nextPc    = romData;
                nextState = stateThread2;
            end
            stateThread2: nextState = stateDecode;

            //////////////////////////////////////////////////
            // Decode
            //////////////////////////////////////////////////
            stateDecode: begin
                ctrl.latchInstr = 1'b1;
                nextPcOffset    = 1'b1;
                nextRegSelectB  = fetchCode inside {instrReadB, instrWriteB,
                                                    instrMathsB, instrLoadImmB};
                case (fetchCode)
                    instrReadA, instrReadB:       nextState = stateReadStart;
                    instrWriteA, instrWriteB:     nextState = stateWriteStart;
                    instrMathsA, instrMathsB:     nextState = stateMaths;
                    instrBranch:                  nextState = stateBranch;
                    instrGoto:                    nextState = stateGoto;
                    instrEndThread:               nextState = stateIdle;
                    instrLoadImmA, instrLoadImmB: nextState = stateLoadImm;
                    default: begin
                        // Unknown codes stay on the same byte
                        nextState    = stateDecode;
                        nextPcOffset = 1'b0;
                    end
                endcase
            end

            // Read fetches the address byte, drives it, waits and captures
            stateReadStart: nextState = stateRead0;
            stateRead0: begin
                nextBusAddr = romData;
                nextState   = stateRead1;
            end
            stateRead1: begin
                nextPc    = pc + 2'd2;
                nextState = stateRead2;
            end
            stateRead2: begin
                ctrl.loadFromBus = 1'b1;
                nextState        = stateDecode;
            end

            // Write puts address, data and strobe on the bus together next cycle
            stateWriteStart: begin
                nextPc    = pc + 2'd2;
                nextState = stateWrite0;
            end
            stateWrite0: begin
                nextBusAddr          = romData;
                nextWriteEnable      = 1'b1;
                ctrl.selectWriteData = 1'b1;
                nextState            = stateDecode;
            end

            // Maths result is ready straight after decode
            stateMaths: begin
                ctrl.loadFromAlu = 1'b1;
                nextPc           = pc + 1'b1;
                nextState        = stateMaths0;
            end
            stateMaths0: nextState = stateDecode;

            // Branch
            stateBranch: begin
                nextPc       = pc + 1'b1;
                // Keep pointing one ahead so a fall-through fetches pc+2
                nextPcOffset = 1'b1;
                nextState    = stateBranch0;
            end
            stateBranch0: begin
                if (branchTaken) begin
                    nextPc    = romData;
                    nextState = stateBranch1;
                end else begin
                    nextPc    = pc + 1'b1;
                    nextState = stateDecode;
                end
            end
            stateBranch1: nextState = stateDecode;

            // Goto
            stateGoto: nextState = stateGoto0;
            stateGoto0: begin
                nextPc    = romData;
                nextState = stateGoto1;
            end
            stateGoto1: nextState = stateDecode;

            // Load immediate from the operand byte
            stateLoadImm: nextState = stateLoadImm0;
            stateLoadImm0: begin
                ctrl.loadFromRom = 1'b1;
                nextPc           = pc + 2'd2;
                nextState        = stateLoadImm1;
            end
            stateLoadImm1: nextState = stateDecode;

            default: nextState = stateDecode;
        endcase
    end

endmodule

/* logic/registerDatapath.sv */
`timescale 1ns/100ps
`include "microCpu_params.svh"

module registerDatapath (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic [`DATA_WIDTH-1:0]     romData,
    input  logic [`DATA_WIDTH-1:0]     busDataIn,
    input  microCpuPkg::datapathCtrl_t ctrl,
    output logic [`DATA_WIDTH-1:0]     busDataOut,
    output logic                       branchTaken
);
    import microCpuPkg::*;

    logic [`DATA_WIDTH-1:0] regA;
    logic [`DATA_WIDTH-1:0] regB;
    instrWord_t             instrWord;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] loadData;
    logic                   loadEnable;
    logic                   compareTrue;

    // ALU sees the latched word, not the live ROM byte
    alu aluUnit (
        .regA        (regA),
        .regB        (regB),
        .instr       (instrWord),
        .result      (aluResult),
        .compareTrue (compareTrue)
    );

    //////////////////////////////////////////////////
    // Register load path
    //////////////////////////////////////////////////

    // At most one load source strobes per cycle
    always_comb begin
        loadEnable = ctrl.loadFromBus | ctrl.loadFromRom | ctrl.loadFromAlu;
        if (ctrl.loadFromBus) begin
            loadData = busDataIn;
        end else if (ctrl.loadFromRom) begin
            loadData = romData;
        end else begin
            loadData = aluResult;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
        end else if (loadEnable) begin
            if (ctrl.regSelect) begin
                regB <= loadData;
            end else begin
                regA <= loadData;
            end
        end
    end

    // Instruction byte captured in decode, write data one cycle before the strobe
    always_ff @(posedge CLK) begin
        if (ctrl.latchInstr) begin
            instrWord <= romData;
        end
        if (ctrl.selectWriteData) begin
            busDataOut <= ctrl.regSelect ? regB : regA;
        end
    end

    assign branchTaken = compareTrue;

endmodule

/* logic/alu.sv */
`timescale 1ns/100ps
`include "microCpu_params.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] regA,
    input  logic [`DATA_WIDTH-1:0] regB,
    input  microCpuPkg::instrWord_t instr,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   compareTrue
);
    import microCpuPkg::*;

    //////////////////////////////////////////////////
    // Maths view of the instruction
    //////////////////////////////////////////////////

    // All results wrap to the data width
    always_comb begin
        case (instr.maths.op)
            aluAdd:       result = regA + regB;
            // A minus B
            aluSub:       result = regA - regB;
            aluAnd:       result = regA & regB;
            aluOr:        result = regA | regB;
            aluXor:       result = regA ^ regB;
            aluShiftLeft: result = regA << 1;
            default:      result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Branch view of the same word
    //////////////////////////////////////////////////

    // Unsigned compares, unknown conditions never branch
    always_comb begin
        case (instr.branch.cond)
            condEqual:   compareTrue = (regA == regB);
            condGreater: compareTrue = (regA > regB);
            condLess:    compareTrue = (regA < regB);
            default:     compareTrue = 1'b0;
        endcase
    end

endmodule

/* logic/microCpuPkg.sv */
`include "microCpu_params.svh"

package microCpuPkg;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////

    // Operation code in the low nibble of the first instruction byte
    typedef enum logic [3:0] {
        instrReadA     = 4'h0,
        instrReadB     = 4'h1,
        instrWriteA    = 4'h2,
        instrWriteB    = 4'h3,
        instrMathsA    = 4'h4,
        instrMathsB    = 4'h5,
        instrBranch    = 4'h6,
        instrGoto      = 4'h7,
        instrEndThread = 4'h8,
        instrLoadImmA  = 4'hD,
        instrLoadImmB  = 4'hE
    } instrCode_t;

    // Maths operation, high nibble of a maths instruction
    typedef enum logic [3:0] {
        aluAdd       = 4'h0,
        aluSub       = 4'h1,
        aluAnd       = 4'h2,
        aluOr        = 4'h3,
        aluXor       = 4'h4,
        aluShiftLeft = 4'h5
    } aluOp_t;

    // Branch condition, high nibble of a branch instruction
    typedef enum logic [3:0] {
        condEqual   = 4'h0,
        condGreater = 4'h1,
        condLess    = 4'h2
    } branchCond_t;

    typedef struct packed {
        aluOp_t     op;
        instrCode_t code;
    } mathsWord_t;

    typedef struct packed {
        branchCond_t cond;
        instrCode_t  code;
    } branchWord_t;

    // Same byte, read as a maths word or as a branch word
    typedef union packed {
        mathsWord_t  maths;
        branchWord_t branch;
    } instrWord_t;

    //////////////////////////////////////////////////
    // Control and bus bundles
    //////////////////////////////////////////////////

    // Sequencer to datapath strobes, all valid for one cycle
    typedef struct packed {
        logic latchInstr;
        logic regSelect;
        logic loadFromBus;
        logic loadFromRom;
        logic loadFromAlu;
        logic selectWriteData;
    } datapathCtrl_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
        logic                   writeEnable;
    } busReq_t;

endpackage

/* include/microCpu_params.svh */
`ifndef MICRO_CPU_PARAMS_SVH
`define MICRO_CPU_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////

// Data bus, registers, ROM and RAM addresses are all one byte
`define DATA_WIDTH 8

// Interrupt lines, line 0 has priority
`define IRQ_COUNT 2

//////////////////////////////////////////////////
// Fixed addresses
//////////////////////////////////////////////////

// ROM bytes holding the thread start address for each line
`define IRQ_A_VECTOR 8'hFF
`define IRQ_B_VECTOR 8'hFE

// Bus address parked here between accesses
`define IDLE_BUS_ADDR 8'hFF

`endif
